//--- axil_cache_port.sv
`timescale 1ns/10ps

module axil_cache_port import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  logic [addr_width-1:0] s_axil_awaddr,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    input  logic [word_width-1:0] s_axil_wdata,
    input  logic [3:0]            s_axil_wstrb,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    output logic [1:0]            s_axil_bresp,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    input  logic [addr_width-1:0] s_axil_araddr,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    output logic [word_width-1:0] s_axil_rdata,
    output logic [1:0]            s_axil_rresp,
    cpu_req_if.port               req
);

    // busy from accept until the master takes the response
    logic busy;
    logic last_rd;
    logic rd_pend;
    logic wr_pend;
    logic pick_rd;
    logic pick_wr;

    assign rd_pend = s_axil_arvalid;
    // a write needs address and data together
    assign wr_pend = s_axil_awvalid && s_axil_wvalid;

    // alternate when both kinds wait
    assign pick_rd = rd_pend && !(wr_pend && last_rd);
    assign pick_wr = wr_pend && !pick_rd;

    assign s_axil_arready = !busy && pick_rd;
    assign s_axil_awready = !busy && pick_wr;
    assign s_axil_wready  = !busy && pick_wr;

    assign s_axil_bresp = 2'b00;
    assign s_axil_rresp = 2'b00;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy          <= 1'b0;
            last_rd       <= 1'b0;
            req.req_valid <= 1'b0;
            s_axil_rvalid <= 1'b0;
            s_axil_bvalid <= 1'b0;
        end else begin
            if (s_axil_arready || s_axil_awready) begin
                busy          <= 1'b1;
                req.req_valid <= 1'b1;
                last_rd       <= s_axil_arready;
            end
            if (req.req_valid && req.req_ready) begin
                req.req_valid <= 1'b0;
            end
            // response goes out one cycle after the controller finishes
            if (req.resp_valid) begin
                if (req.req_op == op_read) begin
                    s_axil_rvalid <= 1'b1;
                end else begin
                    s_axil_bvalid <= 1'b1;
                end
            end
            if (s_axil_rvalid && s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
                busy          <= 1'b0;
            end
            if (s_axil_bvalid && s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
                busy          <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_axil_arready) begin
            req.req_op    <= op_read;
            req.req_addr  <= s_axil_araddr;
            req.req_wdata <= '0;
            req.req_wstrb <= '0;
        end else if (s_axil_awready) begin
            req.req_op    <= op_write;
            req.req_addr  <= s_axil_awaddr;
            req.req_wdata <= s_axil_wdata;
            req.req_wstrb <= s_axil_wstrb;
        end
        if (req.resp_valid) begin
            s_axil_rdata <= req.resp_rdata;
        end
    end

endmodule

//--- compile.f
dcache_pkg.sv
dcache_if.sv
axil_cache_port.sv
dcache_main_array.sv
victim_dcache.sv
dcache_ctrl.sv
dcache_top.sv
dcache_assert.sv
tb_dcache.sv

//--- dcache_assert.sv
`timescale 1ns/10ps

module dcache_assert import dcache_pkg::*; #(
    parameter int victim_entries = 4
) (
    input logic                      clk,
    input logic                      rstn,
    input logic                      rvalid,
    input logic                      rready,
    input logic [word_width-1:0]     rdata,
    input logic                      bvalid,
    input logic                      bready,
    input logic                      mem_req,
    input logic                      mem_ack,
    input logic                      mem_we,
    input logic [addr_width-1:0]     mem_addr,
    input logic [word_width-1:0]     mem_wdata,
    input logic [3:0]                mem_wstrb,
    input logic [victim_entries-1:0] vic_hit,
    input ctrl_state_t               state,
    input logic                      req_ready
);

    // number of failed assertions
    int fail_count = 0;

    // entries are invalidated on swap, so a key lives in one slot only
    a_victim_single: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(vic_hit))
        else begin
            $error("more than one victim entry matches the lookup key");
            fail_count++;
        end

    a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("read response dropped or changed before rready");
            fail_count++;
        end

    a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
        bvalid && !bready |=> bvalid)
        else begin
            $error("write response dropped before bready");
            fail_count++;
        end

    a_mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_ack |=> mem_req && $stable(mem_we) && $stable(mem_addr)
            && $stable(mem_wdata) && $stable(mem_wstrb))
        else begin
            $error("memory request changed before mem_ack");
            fail_count++;
        end

    a_ready_idle: assert property (@(posedge clk) disable iff (!rstn)
        (state != st_idle) |-> !req_ready)
        else begin
            $error("req_ready high outside the idle state");
            fail_count++;
        end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int victim_entries = 4
) (
    input  logic                               clk,
    input  logic                               rstn,
    cpu_req_if.ctrl                            req,
    victim_if.ctrl                             vc,
    output logic [index_width-1:0]             rd_index,
    input  logic [tag_width-1:0]               rd_tag,
    input  logic                               rd_valid,
    input  logic [line_width-1:0]              rd_line,
    output logic                               fill_en,
    output logic [tag_width-1:0]               fill_tag,
    output logic [line_width-1:0]              fill_line,
    output logic                               word_en,
    output logic [$clog2(words_per_line)-1:0]  word_sel,
    output logic [word_width-1:0]              word_data,
    output logic [3:0]                         word_strb,
    output logic                               mem_req,
    output logic                               mem_we,
    output logic [addr_width-1:0]              mem_addr,
    output logic [word_width-1:0]              mem_wdata,
    output logic [3:0]                         mem_wstrb,
    input  logic [line_width-1:0]              mem_rline,
    input  logic                               mem_ack
);

    localparam int sel_width = $clog2(words_per_line);

    ctrl_state_t           state;
    req_op_t               op_q;
    logic [addr_width-1:0] addr_q;
    logic [word_width-1:0] wdata_q;
    logic [3:0]            wstrb_q;
    logic [word_width-1:0] rdata_q;
    logic [tag_width-1:0]  tag_q;
    logic [index_width-1:0] index_q;
    logic [sel_width-1:0]  sel_q;
    logic                  main_hit;
    logic                  vic_hit;
    logic [line_width-1:0] swap_line;

    function automatic logic [line_width-1:0] merge_word(
        input logic [line_width-1:0] line,
        input logic [sel_width-1:0]  sel,
        input logic [word_width-1:0] data,
        input logic [3:0]            strb
    );
        logic [line_width-1:0] res;
        res = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[sel*word_width + b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign tag_q   = addr_q[addr_width-1 -: tag_width];
    assign index_q = addr_q[offset_width +: index_width];
    assign sel_q   = addr_q[2 +: sel_width];

    assign main_hit = rd_valid && (rd_tag == tag_q);
    assign vic_hit  = vc.victim_hit;

    // a write that hits the victim is merged into the swapped-in line
    assign swap_line = (op_q == op_write) ?
                       merge_word(vc.data_out, sel_q, wdata_q, wstrb_q) : vc.data_out;

    assign req.req_ready  = (state == st_idle);
    assign req.resp_valid = (state == st_resp);
    assign req.resp_rdata = rdata_q;

    assign rd_index  = index_q;
    assign fill_tag  = tag_q;
    assign fill_en   = (state == st_swap) || (state == st_fill_wait && mem_ack);
    assign fill_line = (state == st_swap) ? swap_line : mem_rline;
    assign word_en   = (state == st_lookup) && (op_q == op_write) && main_hit;
    assign word_sel  = sel_q;
    assign word_data = wdata_q;
    assign word_strb = wstrb_q;

    // evicted valid main line goes to the victim buffer on every fill
    assign vc.r_key   = {tag_q, index_q};
    assign vc.inv_key = {tag_q, index_q};
    assign vc.inv     = (state == st_swap);
    assign vc.we      = fill_en && rd_valid;
    assign vc.w_key   = {rd_tag, index_q};
    assign vc.data_in = rd_line;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= st_idle;
            mem_req  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req.req_valid) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (main_hit) begin
                        state <= (op_q == op_write) ? st_wt_req : st_resp;
                    end else if (vic_hit) begin
                        state <= st_swap;
                    end else begin
                        // no write-allocate
                        state <= (op_q == op_write) ? st_wt_req : st_fill_req;
                    end
                end
                st_swap: begin
                    state <= (op_q == op_write) ? st_wt_req : st_resp;
                end
                st_fill_req, st_wt_req: begin
                    mem_req <= 1'b1;
                    state   <= (state == st_fill_req) ? st_fill_wait : st_wt_wait;
                end
                st_fill_wait, st_wt_wait: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= st_resp;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req.req_valid) begin
            op_q    <= req.req_op;
            addr_q  <= req.req_addr;
            wdata_q <= req.req_wdata;
            wstrb_q <= req.req_wstrb;
        end
        if (state == st_lookup && main_hit) begin
            rdata_q <= rd_line[sel_q*word_width +: word_width];
        end
        if (state == st_swap) begin
            rdata_q <= vc.data_out[sel_q*word_width +: word_width];
        end
        if (state == st_fill_wait && mem_ack) begin
            rdata_q <= mem_rline[sel_q*word_width +: word_width];
        end
        // request fields only change while no request is up
        if (state == st_fill_req) begin
            mem_we   <= 1'b0;
            mem_addr <= {addr_q[addr_width-1:offset_width], {offset_width{1'b0}}};
        end
        if (state == st_wt_req) begin
            mem_we    <= 1'b1;
            mem_addr  <= {addr_q[addr_width-1:2], 2'b00};
            mem_wdata <= wdata_q;
            mem_wstrb <= wstrb_q;
        end
    end

endmodule

//--- dcache_if.sv
`timescale 1ns/10ps

// single request channel between the AXI4-Lite port and the controller
interface cpu_req_if import dcache_pkg::*; ();

    logic                  req_valid;
    logic                  req_ready;
    req_op_t               req_op;
    logic [addr_width-1:0] req_addr;
    logic [word_width-1:0] req_wdata;
    logic [3:0]            req_wstrb;
    logic                  resp_valid;
    logic [word_width-1:0] resp_rdata;

    modport port (
        output req_valid, req_op, req_addr, req_wdata, req_wstrb,
        input  req_ready, resp_valid, resp_rdata
    );

    modport ctrl (
        input  req_valid, req_op, req_addr, req_wdata, req_wstrb,
        output req_ready, resp_valid, resp_rdata
    );

endinterface

// lookup, push and invalidate path of the victim buffer
interface victim_if import dcache_pkg::*; ();

    logic [key_width-1:0]  r_key;
    logic                  victim_hit;
    logic [line_width-1:0] data_out;
    logic [key_width-1:0]  w_key;
    logic                  we;
    logic [line_width-1:0] data_in;
    logic                  inv;
    logic [key_width-1:0]  inv_key;

    modport ctrl (
        output r_key, w_key, we, data_in, inv, inv_key,
        input  victim_hit, data_out
    );

    modport victim (
        input  r_key, w_key, we, data_in, inv, inv_key,
        output victim_hit, data_out
    );

endinterface

//--- dcache_main_array.sv
`timescale 1ns/10ps

module dcache_main_array import dcache_pkg::*; (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic [index_width-1:0]             rd_index,
    output logic [tag_width-1:0]               rd_tag,
    output logic                               rd_valid,
    output logic [line_width-1:0]              rd_line,
    input  logic                               fill_en,
    input  logic [tag_width-1:0]               fill_tag,
    input  logic [line_width-1:0]              fill_line,
    input  logic                               word_en,
    input  logic [$clog2(words_per_line)-1:0]  word_sel,
    input  logic [word_width-1:0]              word_data,
    input  logic [3:0]                         word_strb
);

    logic [tag_width-1:0]  tags  [num_lines];
    logic [line_width-1:0] lines [num_lines];
    logic [num_lines-1:0]  valid;

    // direct-mapped, read in the same cycle
    assign rd_tag   = tags[rd_index];
    assign rd_valid = valid[rd_index];
    assign rd_line  = lines[rd_index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[rd_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[rd_index]  <= fill_tag;
            lines[rd_index] <= fill_line;
        end else if (word_en) begin
            // merge only the strobed bytes
            for (int b = 0; b < 4; b++) begin
                if (word_strb[b]) begin
                    lines[rd_index][word_sel*word_width + b*8 +: 8] <= word_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

    // cpu address and data
    localparam int addr_width = 32;
    localparam int word_width = 32;

    // one cache line is 64 bytes
    localparam int line_width = 512;

    // address split: tag | index | byte offset
    localparam int tag_width    = 20;
    localparam int index_width  = 6;
    localparam int offset_width = 6;

    // victim buffer key is tag plus index
    localparam int key_width = tag_width + index_width;

    localparam int num_lines      = 1 << index_width;
    localparam int words_per_line = line_width / word_width;

    // internal cache request kind
    typedef enum logic {
        op_read,
        op_write
    } req_op_t;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_swap,
        st_fill_req,
        st_fill_wait,
        st_wt_req,
        st_wt_wait,
        st_resp
    } ctrl_state_t;

endpackage

//--- dcache_top.sv
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; #(
    parameter int victim_entries = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  logic [addr_width-1:0] s_axil_awaddr,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    input  logic [word_width-1:0] s_axil_wdata,
    input  logic [3:0]            s_axil_wstrb,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    output logic [1:0]            s_axil_bresp,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    input  logic [addr_width-1:0] s_axil_araddr,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    output logic [word_width-1:0] s_axil_rdata,
    output logic [1:0]            s_axil_rresp,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [addr_width-1:0] mem_addr,
    output logic [word_width-1:0] mem_wdata,
    output logic [3:0]            mem_wstrb,
    input  logic [line_width-1:0] mem_rline,
    input  logic                  mem_ack
);

    // controller to main array
    logic [index_width-1:0]            rd_index;
    logic [tag_width-1:0]              rd_tag;
    logic                              rd_valid;
    logic [line_width-1:0]             rd_line;
    logic                              fill_en;
    logic [tag_width-1:0]              fill_tag;
    logic [line_width-1:0]             fill_line;
    logic                              word_en;
    logic [$clog2(words_per_line)-1:0] word_sel;
    logic [word_width-1:0]             word_data;
    logic [3:0]                        word_strb;

    cpu_req_if req_bus ();
    victim_if  vc_bus ();

    axil_cache_port i_port (
        .clk, .rstn,
        .s_axil_awvalid, .s_axil_awready, .s_axil_awaddr,
        .s_axil_wvalid, .s_axil_wready, .s_axil_wdata, .s_axil_wstrb,
        .s_axil_bvalid, .s_axil_bready, .s_axil_bresp,
        .s_axil_arvalid, .s_axil_arready, .s_axil_araddr,
        .s_axil_rvalid, .s_axil_rready, .s_axil_rdata, .s_axil_rresp,
        .req (req_bus.port)
    );

    dcache_ctrl #(.victim_entries(victim_entries)) i_ctrl (
        .clk, .rstn,
        .req (req_bus.ctrl),
        .vc  (vc_bus.ctrl),
        .rd_index, .rd_tag, .rd_valid, .rd_line,
        .fill_en, .fill_tag, .fill_line,
        .word_en, .word_sel, .word_data, .word_strb,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rline, .mem_ack
    );

    dcache_main_array i_main (
        .clk, .rstn,
        .rd_index, .rd_tag, .rd_valid, .rd_line,
        .fill_en, .fill_tag, .fill_line,
        .word_en, .word_sel, .word_data, .word_strb
    );

    victim_dcache #(.victim_entries(victim_entries)) i_victim (
        .clk, .rstn,
        .vc (vc_bus.victim)
    );

endmodule

//--- tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache import dcache_pkg::*;;

    localparam int vic_n     = 4;
    localparam int num_txn   = 400;
    localparam int max_cycle = num_txn * 20 + 20;

    logic                  clk;
    logic                  rstn;
    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready;
    logic [addr_width-1:0] awaddr, araddr;
    logic [word_width-1:0] wdata, rdata;
    logic [3:0]            wstrb;
    logic [1:0]            bresp, rresp;
    logic                  mem_req, mem_we, mem_ack;
    logic [addr_width-1:0] mem_addr;
    logic [word_width-1:0] mem_wdata;
    logic [3:0]            mem_wstrb;
    logic [line_width-1:0] mem_rline;

    integer seed = 32'hcc3d4b67;
    int     cycles;
    int     txn_count;

    // memory model state
    logic [word_width-1:0] mem_words [logic [addr_width-1:0]];
    int                    fetch_cnt;
    logic [key_width-1:0]  fetch_key;
    int                    wr_cnt;
    logic [addr_width-1:0] wr_addr;
    logic [word_width-1:0] wr_data;
    logic [3:0]            wr_strb;

    // reference cache model
    bit                    m_valid [num_lines];
    logic [tag_width-1:0]  m_tag   [num_lines];
    bit                    v_valid [vic_n];
    logic [key_width-1:0]  v_key   [vic_n];
    int                    v_ptr;

    dcache_top #(.victim_entries(vic_n)) i_dcache_top (
        .clk, .rstn,
        .s_axil_awvalid(awvalid), .s_axil_awready(awready), .s_axil_awaddr(awaddr),
        .s_axil_wvalid(wvalid), .s_axil_wready(wready), .s_axil_wdata(wdata),
        .s_axil_wstrb(wstrb),
        .s_axil_bvalid(bvalid), .s_axil_bready(bready), .s_axil_bresp(bresp),
        .s_axil_arvalid(arvalid), .s_axil_arready(arready), .s_axil_araddr(araddr),
        .s_axil_rvalid(rvalid), .s_axil_rready(rready), .s_axil_rdata(rdata),
        .s_axil_rresp(rresp),
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rline, .mem_ack
    );

    bind dcache_top dcache_assert #(.victim_entries(victim_entries)) i_assert (
        .clk(clk), .rstn(rstn),
        .rvalid(s_axil_rvalid), .rready(s_axil_rready), .rdata(s_axil_rdata),
        .bvalid(s_axil_bvalid), .bready(s_axil_bready),
        .mem_req(mem_req), .mem_ack(mem_ack), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .vic_hit(i_victim.hit), .state(i_ctrl.state), .req_ready(req_bus.req_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycle) begin
            $display("timeout: the DUT stopped answering after %0d cycles", cycles);
            $display("tests failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (i_dcache_top.i_assert.fail_count != 0) begin
            $display("a bound assertion failed at %0t ns", $time);
            $display("tests failed");
            $fatal(1);
        end
    end

    // initial memory contents, mixed from every address bit
    function automatic logic [word_width-1:0] addr_hash(input logic [addr_width-1:0] a);
        return (a * 32'h2545f491) ^ {a[15:0], a[31:16]} ^ 32'h9e3779b9;
    endfunction

    function automatic logic [word_width-1:0] get_word(input logic [addr_width-1:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return addr_hash(a);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input logic [word_width-1:0] exp, input logic [word_width-1:0] got,
                              input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("%s expected %h got %h", what, exp, got));
        end
    endtask

    task automatic check_fetch(input bit exp, input bit got, input logic [key_width-1:0] key);
        if (got != exp) begin
            stop_on_error($sformatf("line read for key %h expected %0b got %0b", key, exp, got));
        end
    endtask

    task automatic check_resp(input logic [1:0] got);
        if (got !== 2'b00) begin
            stop_on_error($sformatf("response expected OKAY got %b", got));
        end
    endtask

    // memory side: random latency, line reads and word writes
    initial begin
        int delay;
        logic [addr_width-1:0] a;
        logic [word_width-1:0] w;
        mem_ack   = 1'b0;
        mem_rline = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(negedge clk);
                if (mem_we) begin
                    a = mem_addr;
                    w = get_word(a);
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b]) begin
                            w[b*8 +: 8] = mem_wdata[b*8 +: 8];
                        end
                    end
                    mem_words[a] = w;
                    wr_cnt++;
                    wr_addr = mem_addr;
                    wr_data = mem_wdata;
                    wr_strb = mem_wstrb;
                end else begin
                    for (int i = 0; i < words_per_line; i++) begin
                        mem_rline[i*word_width +: word_width] = get_word(mem_addr + 4 * i);
                    end
                    fetch_cnt++;
                    fetch_key = mem_addr[addr_width-1:offset_width];
                end
                mem_ack = 1'b1;
                @(negedge clk);
                mem_ack = 1'b0;
            end
        end
    end

    task automatic push_victim(input logic [key_width-1:0] key);
        v_key[v_ptr]   = key;
        v_valid[v_ptr] = 1'b1;
        v_ptr          = (v_ptr + 1) % vic_n;
    endtask

    // predicts whether the access reads a line from memory
    task automatic model_access(input req_op_t op, input logic [addr_width-1:0] addr,
                                output bit fetch);
        logic [index_width-1:0] idx;
        logic [tag_width-1:0]   tag;
        logic [key_width-1:0]   key;
        bit                     vhit;
        idx   = addr[offset_width +: index_width];
        tag   = addr[addr_width-1 -: tag_width];
        key   = {tag, idx};
        fetch = 1'b0;
        vhit  = 1'b0;
        for (int i = 0; i < vic_n; i++) begin
            if (v_valid[i] && v_key[i] == key) begin
                vhit = 1'b1;
            end
        end
        if (m_valid[idx] && m_tag[idx] == tag) begin
            return;
        end
        if (vhit) begin
            // the swapped-out line may land in the slot just freed
            for (int i = 0; i < vic_n; i++) begin
                if (v_key[i] == key) begin
                    v_valid[i] = 1'b0;
                end
            end
        end else if (op == op_write) begin
            return;
        end else begin
            fetch = 1'b1;
        end
        if (m_valid[idx]) begin
            push_victim({m_tag[idx], idx});
        end
        m_valid[idx] = 1'b1;
        m_tag[idx]   = tag;
    endtask

    task automatic run_read(input logic [addr_width-1:0] addr);
        bit exp_fetch;
        int f0;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        f0 = fetch_cnt;
        model_access(op_read, addr, exp_fetch);
        @(negedge clk);
        arvalid = 1'b0;
        forever begin
            rready = ($random(seed) & 3) != 0;
            if (rvalid && rready) begin
                break;
            end
            @(negedge clk);
        end
        check_resp(rresp);
        check_word(get_word({addr[addr_width-1:2], 2'b00}), rdata, "read data");
        if (fetch_cnt - f0 > 1) begin
            stop_on_error("a single read caused more than one line read");
        end
        check_fetch(exp_fetch,
                    (fetch_cnt - f0 == 1) && (fetch_key == addr[addr_width-1:offset_width]),
                    addr[addr_width-1:offset_width]);
        @(negedge clk);
        rready = 1'b0;
        txn_count++;
    endtask

    task automatic run_write(input logic [addr_width-1:0] addr, input logic [word_width-1:0] d,
                             input logic [3:0] s);
        bit exp_fetch;
        int f0;
        int w0;
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = d;
        wstrb   = s;
        #1;
        while (!(awready && wready)) begin
            if (awready || wready) begin
                stop_on_error("awready and wready did not rise together");
            end
            @(negedge clk);
            #1;
        end
        f0 = fetch_cnt;
        w0 = wr_cnt;
        model_access(op_write, addr, exp_fetch);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        forever begin
            bready = ($random(seed) & 3) != 0;
            if (bvalid && bready) begin
                break;
            end
            @(negedge clk);
        end
        check_resp(bresp);
        if (wr_cnt - w0 != 1) begin
            stop_on_error("a write did not give exactly one memory word write");
        end
        check_fetch(exp_fetch, fetch_cnt != f0, addr[addr_width-1:offset_width]);
        check_word({addr[addr_width-1:2], 2'b00}, wr_addr, "write-through address");
        check_word(d, wr_data, "write-through data");
        check_word({28'b0, s}, {28'b0, wr_strb}, "write-through strobe");
        @(negedge clk);
        bready = 1'b0;
        txn_count++;
    endtask

    // a few indices with six tags each keep evictions frequent
    function automatic logic [addr_width-1:0] pick_addr();
        logic [index_width-1:0] idx;
        logic [tag_width-1:0]   tag;
        logic [3:0]             word;
        case ($unsigned($random(seed)) % 3)
            0: idx = 6'd5;
            1: idx = 6'd21;
            default: idx = 6'd46;
        endcase
        tag  = 20'h1a000 + ($unsigned($random(seed)) % 6);
        word = $random(seed);
        return {tag, idx, word, 2'b00};
    endfunction

    initial begin
        logic [addr_width-1:0] a1;
        logic [addr_width-1:0] a2;
        int kind;
        rstn = 1'b0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        awaddr = '0;
        araddr = '0;
        wdata  = '0;
        wstrb  = '0;
        cycles = 0;
        txn_count = 0;
        fetch_cnt = 0;
        wr_cnt = 0;
        v_ptr = 0;
        for (int i = 0; i < num_lines; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < vic_n; i++) begin
            v_valid[i] = 1'b0;
        end
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        // ping-pong on index 9, then five more tags push the oldest out
        for (int r = 0; r < 3; r++) begin
            run_read({20'h00c00, 6'd9, 6'h04});
            run_read({20'h00c01, 6'd9, 6'h08});
        end
        for (int t = 2; t < 7; t++) begin
            run_read({20'(32'h00c00 + t), 6'd9, 6'h10});
        end
        run_read({20'h00c00, 6'd9, 6'h04});
        while (txn_count < num_txn) begin
            kind = $unsigned($random(seed)) % 8;
            a1   = pick_addr();
            a2   = pick_addr();
            if (kind < 4) begin
                run_read(a1);
            end else if (kind < 6) begin
                run_write(a1, $random(seed), $random(seed));
            end else begin
                fork
                    run_read(a1);
                    run_write(a2, $random(seed), $random(seed));
                join
            end
        end
        if (i_dcache_top.i_assert.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

//--- victim_dcache.sv
`timescale 1ns/10ps

module victim_dcache import dcache_pkg::*; #(
    parameter int victim_entries = 4
) (
    input  logic      clk,
    input  logic      rstn,
    victim_if.victim  vc
);

    localparam int cnt_width = $clog2(victim_entries);

    logic [key_width-1:0]      keys  [victim_entries];
    logic [line_width-1:0]     lines [victim_entries];
    logic [victim_entries-1:0] valid;
    logic [victim_entries-1:0] hit;
    // next slot to overwrite, fifo order
    logic [cnt_width-1:0]      wr_ptr;

    // fully associative compare, at most one entry can match
    always_comb begin
        vc.data_out = '0;
        for (int i = 0; i < victim_entries; i++) begin
            hit[i] = valid[i] && (keys[i] == vc.r_key);
            if (hit[i]) begin
                vc.data_out = vc.data_out | lines[i];
            end
        end
    end

    assign vc.victim_hit = |hit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid  <= '0;
            wr_ptr <= '0;
        end else begin
            if (vc.inv) begin
                for (int i = 0; i < victim_entries; i++) begin
                    if (keys[i] == vc.inv_key) begin
                        valid[i] <= 1'b0;
                    end
                end
            end
            // later assignment, so a write beats an invalidate on one slot
            if (vc.we) begin
                valid[wr_ptr] <= 1'b1;
                wr_ptr        <= wr_ptr + 1'b1;
            end
        end
    end

    // invalidated slots are not skipped
    always_ff @(posedge clk) begin
        if (vc.we) begin
            keys[wr_ptr]  <= vc.w_key;
            lines[wr_ptr] <= vc.data_in;
        end
    end

endmodule
